/* logic/riscv_dcache_pkg.sv */
`default_nettype none

package riscv_dcache_pkg;

  //////////////////// sizes
  localparam int DATA_WIDTH   = 128;  // bits per line
  localparam int DATAPBLOCK   = 16;   // bytes per line
  localparam int CACHE_DEPTH  = 16;
  localparam int MEM_DEPTH    = 256;  // dram blocks
  localparam int BYTE_OFF     = 4;
  localparam int INDEX        = 4;
  localparam int TAG          = 4;
  localparam int ADDR         = BYTE_OFF + INDEX + TAG;  // 12 address bits in use
  localparam int DRAM_LATENCY = 4;
  localparam int LAT_W        = $clog2(DRAM_LATENCY + 1);

  //////////////////// encodings
  typedef enum logic [2:0] {
    IDLE, WRITEBACK, ALLOCATE, AMO_READ, AMO_WRITE, AMO_DONE
  } dcache_state_t;

  // funct5 of the A extension
  typedef enum logic [4:0] {
    AMOADD  = 5'b00000,
    AMOSWAP = 5'b00001,
    AMOXOR  = 5'b00100,
    AMOOR   = 5'b01000,
    AMOAND  = 5'b01100,
    AMOMIN  = 5'b10000,
    AMOMAX  = 5'b10100,
    AMOMINU = 5'b11000,
    AMOMAXU = 5'b11100
  } amo_op_t;

  typedef enum logic [1:0] {ST_BYTE, ST_HALF, ST_WORD, ST_DOUBLE} store_src_t;

  typedef enum logic [1:0] {INSEL_CPU, INSEL_MEM, INSEL_AMO} line_insel_t;

endpackage

`default_nettype wire

/* logic/riscv_amo_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_amo_unit (
  input  riscv_dcache_pkg::amo_op_t i_amo_op,
  input  logic [63:0]               i_rs1data,  // old memory value
  input  logic [63:0]               i_rs2data,
  input  logic                      i_enable,
  output logic [63:0]               o_result
);
  import riscv_dcache_pkg::*;

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(i_rs1data) < $signed(i_rs2data);
  assign lt_unsigned = i_rs1data < i_rs2data;

  always_comb begin
    o_result = '0;
    if (i_enable) begin
      case (i_amo_op)
        AMOADD:  o_result = i_rs1data + i_rs2data;
        AMOSWAP: o_result = i_rs2data;
        AMOXOR:  o_result = i_rs1data ^ i_rs2data;
        AMOOR:   o_result = i_rs1data | i_rs2data;
        AMOAND:  o_result = i_rs1data & i_rs2data;
        AMOMIN:  o_result = lt_signed ? i_rs1data : i_rs2data;
        AMOMAX:  o_result = lt_signed ? i_rs2data : i_rs1data;
        AMOMINU: o_result = lt_unsigned ? i_rs1data : i_rs2data;
        AMOMAXU: o_result = lt_unsigned ? i_rs2data : i_rs1data;
        default: o_result = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/riscv_dcache_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_dcache_fsm (
  input  logic                          i_riscv_dcache_clk,
  input  logic                          i_riscv_dcache_rst,
  input  logic                          i_cpu_wren,
  input  logic                          i_cpu_rden,
  input  logic                          i_cpu_amo,
  input  logic                          i_hit,
  input  logic                          i_dirty,
  input  logic                          i_mem_ready,
  input  logic                          i_globstall,
  output logic                          o_cache_wren,
  output riscv_dcache_pkg::line_insel_t o_cache_insel,
  output logic                          o_mem_rden,
  output logic                          o_mem_wren,
  output logic                          o_set_dirty,
  output logic                          o_set_valid,
  output logic                          o_replace_tag,
  output logic                          o_tag_sel,
  output logic                          o_amo_buffer_en,
  output logic                          o_amo_done,
  output logic                          o_stall
);
  import riscv_dcache_pkg::*;

  dcache_state_t state, next_state;
  logic          cpu_req;

  assign cpu_req   = i_cpu_wren | i_cpu_rden | i_cpu_amo;
  assign o_tag_sel = (state == WRITEBACK);  // victim address to dram

  //////////////////// state register
  // dram pulses come out of a register, high in the first cycle of the state
  always_ff @(posedge i_riscv_dcache_clk or posedge i_riscv_dcache_rst) begin
    if (i_riscv_dcache_rst) begin
      state      <= IDLE;
      o_mem_wren <= 1'b0;
      o_mem_rden <= 1'b0;
    end else begin
      state      <= next_state;
      o_mem_wren <= (next_state == WRITEBACK) && (state != WRITEBACK);
      o_mem_rden <= (next_state == ALLOCATE) && (state != ALLOCATE);
    end
  end

  //////////////////// next state and outputs
  always_comb begin
    next_state      = state;
    o_cache_wren    = 1'b0;
    o_cache_insel   = INSEL_CPU;
    o_set_dirty     = 1'b0;
    o_set_valid     = 1'b0;
    o_replace_tag   = 1'b0;
    o_amo_buffer_en = 1'b0;
    o_amo_done      = 1'b0;
    o_stall         = 1'b1;
    case (state)
      IDLE: begin
        o_stall = cpu_req & (~i_hit | i_cpu_amo);
        if (!i_globstall && cpu_req) begin
          if (!i_hit) begin
            next_state = i_dirty ? WRITEBACK : ALLOCATE;  // miss
          end else if (i_cpu_amo) begin
            next_state = AMO_READ;
          end else if (i_cpu_wren) begin
            o_cache_wren = 1'b1;  // store hit
            o_set_dirty  = 1'b1;
          end
        end
      end
      WRITEBACK: begin
        if (i_mem_ready) next_state = ALLOCATE;
      end
      ALLOCATE: begin
        if (i_mem_ready) begin
          o_cache_wren  = 1'b1;
          o_cache_insel = INSEL_MEM;
          o_set_valid   = 1'b1;  // also clears dirty
          o_replace_tag = 1'b1;
          next_state    = IDLE;
        end
      end
      AMO_READ: begin
        o_amo_buffer_en = 1'b1;  // grab old doubleword
        next_state      = AMO_WRITE;
      end
      AMO_WRITE: begin
        o_cache_wren  = 1'b1;
        o_cache_insel = INSEL_AMO;
        o_set_dirty   = 1'b1;
        next_state    = AMO_DONE;
      end
      AMO_DONE: begin
        o_stall    = 1'b0;
        o_amo_done = 1'b1;
        // wait out globstall so a held request is not replayed
        if (!i_globstall) next_state = IDLE;
      end
      default: next_state = IDLE;
    endcase
  end

endmodule

`default_nettype wire

/* logic/riscv_dcache_tag.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_dcache_tag (
  input  logic                             i_riscv_dcache_clk,
  input  logic                             i_riscv_dcache_rst,
  input  logic [riscv_dcache_pkg::INDEX-1:0] i_index,
  input  logic [riscv_dcache_pkg::TAG-1:0]   i_tag,
  input  logic                             i_set_dirty,
  input  logic                             i_set_valid,
  input  logic                             i_replace_tag,
  output logic                             o_hit,
  output logic                             o_dirty,
  output logic [riscv_dcache_pkg::TAG-1:0]   o_tag_old
);
  import riscv_dcache_pkg::*;

  logic [CACHE_DEPTH-1:0] valid;
  logic [CACHE_DEPTH-1:0] dirty;
  logic [TAG-1:0]         tags [CACHE_DEPTH];

  assign o_tag_old = tags[i_index];
  assign o_hit     = valid[i_index] && (tags[i_index] == i_tag);
  assign o_dirty   = valid[i_index] & dirty[i_index];  // victim needs write-back

  always_ff @(posedge i_riscv_dcache_clk or posedge i_riscv_dcache_rst) begin
    if (i_riscv_dcache_rst) begin
      valid <= '0;
      dirty <= '0;
    end else if (i_set_valid) begin
      valid[i_index] <= 1'b1;
      dirty[i_index] <= 1'b0;  // fresh refill
    end else if (i_set_dirty) begin
      dirty[i_index] <= 1'b1;
    end
  end

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_replace_tag) tags[i_index] <= i_tag;
  end

endmodule

`default_nettype wire

/* logic/riscv_dcache_data.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_dcache_data (
  input  logic                                    i_riscv_dcache_clk,
  input  logic                                    i_wren,
  input  riscv_dcache_pkg::line_insel_t           i_insel,
  input  logic [riscv_dcache_pkg::INDEX-1:0]      i_index,
  input  logic [riscv_dcache_pkg::BYTE_OFF-1:0]   i_byte_offset,
  input  riscv_dcache_pkg::store_src_t            i_store_src,
  input  logic [riscv_dcache_pkg::DATA_WIDTH-1:0] i_data_in,
  output logic [riscv_dcache_pkg::DATA_WIDTH-1:0] o_data_out
);
  import riscv_dcache_pkg::*;

  logic [DATA_WIDTH-1:0] lines [CACHE_DEPTH];
  logic [DATAPBLOCK-1:0] base_mask;
  logic [DATAPBLOCK-1:0] byte_en;
  logic [DATA_WIDTH-1:0] store_data;

  assign o_data_out = lines[i_index];  // combinational read

  //////////////////// byte enables
  always_comb begin
    case (i_store_src)
      ST_BYTE: base_mask = DATAPBLOCK'(16'h0001);
      ST_HALF: base_mask = DATAPBLOCK'(16'h0003);
      ST_WORD: base_mask = DATAPBLOCK'(16'h000f);
      default: base_mask = DATAPBLOCK'(16'h00ff);
    endcase
  end

  assign byte_en = base_mask << i_byte_offset;

  // doubleword already sits in its half, shift low bytes up to the offset
  assign store_data = i_data_in << {i_byte_offset[2:0], 3'b000};

  //////////////////// line write
  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_wren) begin
      if (i_insel == INSEL_CPU) begin
        for (int b = 0; b < DATAPBLOCK; b++) begin
          if (byte_en[b]) lines[i_index][b*8 +: 8] <= store_data[b*8 +: 8];
        end
      end else begin
        lines[i_index] <= i_data_in;  // refill or amo, whole line
      end
    end
  end

endmodule

`default_nettype wire

/* logic/riscv_dcache_dram.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_dcache_dram (
  input  logic                                    i_riscv_dcache_clk,
  input  logic                                    i_riscv_dcache_rst,
  input  logic                                    i_wren,
  input  logic                                    i_rden,
  input  logic [7:0]                              i_addr,
  input  logic [riscv_dcache_pkg::DATA_WIDTH-1:0] i_data_in,
  output logic [riscv_dcache_pkg::DATA_WIDTH-1:0] o_data_out,
  output logic                                    o_mem_ready
);
  import riscv_dcache_pkg::*;

  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
  logic [LAT_W-1:0]      lat_cnt;

  assign o_mem_ready = (lat_cnt == LAT_W'(1));  // last cycle of the count

  always_ff @(posedge i_riscv_dcache_clk or posedge i_riscv_dcache_rst) begin
    if (i_riscv_dcache_rst) begin
      for (int i = 0; i < MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
      o_data_out <= '0;
      lat_cnt    <= '0;
    end else begin
      if (i_wren) mem[i_addr] <= i_data_in;
      if (i_rden) o_data_out <= mem[i_addr];  // held until next read
      if (i_wren | i_rden) begin
        lat_cnt <= LAT_W'(DRAM_LATENCY);
      end else if (lat_cnt != '0) begin
        lat_cnt <= lat_cnt - LAT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* logic/riscv_data_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_data_cache (
  input  logic                         i_riscv_dcache_clk,
  input  logic                         i_riscv_dcache_rst,
  input  logic                         i_riscv_dcache_globstall,
  input  logic                         i_riscv_dcache_cpu_wren,
  input  logic                         i_riscv_dcache_cpu_rden,
  input  logic                         i_riscv_dcache_amo,
  input  riscv_dcache_pkg::store_src_t i_riscv_dcache_store_src,
  input  riscv_dcache_pkg::amo_op_t    i_riscv_dcache_amo_op,
  input  logic [63:0]                  i_riscv_dcache_phys_addr,
  input  logic [63:0]                  i_riscv_dcache_cpu_data_in,
  output logic [63:0]                  o_riscv_dcache_cpu_data_out,
  output logic                         o_riscv_dcache_cpu_stall
);
  import riscv_dcache_pkg::*;

  logic [TAG-1:0]        tag, tag_old;
  logic [INDEX-1:0]      index;
  logic [BYTE_OFF-1:0]   byte_offset;
  logic                  upper_half;  // address bit 3
  logic                  hit, dirty;
  logic                  cache_wren, set_dirty, set_valid, replace_tag, tag_sel;
  logic                  mem_rden, mem_wren, mem_ready;
  logic                  amo_buffer_en, amo_done;
  line_insel_t           cache_insel;
  logic [DATA_WIDTH-1:0] cache_data_in, cache_data_out, mem_data_out;
  logic [TAG+INDEX-1:0]  mem_addr;
  logic [63:0]           cache_dword, amo_old, amo_result;

  assign {tag, index, byte_offset} = i_riscv_dcache_phys_addr[ADDR-1:0];
  assign upper_half  = byte_offset[3];
  assign mem_addr    = tag_sel ? {tag_old, index} : {tag, index};
  assign cache_dword = upper_half ? cache_data_out[127:64] : cache_data_out[63:0];
  assign o_riscv_dcache_cpu_data_out = amo_done ? amo_old : cache_dword;

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (amo_buffer_en) amo_old <= cache_dword;  // old value for rd
  end

  //////////////////// line input
  always_comb begin
    case (cache_insel)
      INSEL_MEM: cache_data_in = mem_data_out;
      INSEL_AMO: cache_data_in = upper_half ? {amo_result, cache_data_out[63:0]}
                                            : {cache_data_out[127:64], amo_result};
      default:   cache_data_in = upper_half ? {i_riscv_dcache_cpu_data_in, 64'b0}
                                            : {64'b0, i_riscv_dcache_cpu_data_in};
    endcase
  end

  //////////////////// blocks
  riscv_dcache_fsm u_fsm (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),  .i_riscv_dcache_rst (i_riscv_dcache_rst),
    .i_cpu_wren (i_riscv_dcache_cpu_wren),     .i_cpu_rden (i_riscv_dcache_cpu_rden),
    .i_cpu_amo (i_riscv_dcache_amo),           .i_hit (hit),
    .i_dirty (dirty),                          .i_mem_ready (mem_ready),
    .i_globstall (i_riscv_dcache_globstall),   .o_cache_wren (cache_wren),
    .o_cache_insel (cache_insel),              .o_mem_rden (mem_rden),
    .o_mem_wren (mem_wren),                    .o_set_dirty (set_dirty),
    .o_set_valid (set_valid),                  .o_replace_tag (replace_tag),
    .o_tag_sel (tag_sel),                      .o_amo_buffer_en (amo_buffer_en),
    .o_amo_done (amo_done),                    .o_stall (o_riscv_dcache_cpu_stall)
  );

  riscv_dcache_tag u_tag (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),  .i_riscv_dcache_rst (i_riscv_dcache_rst),
    .i_index (index),                          .i_tag (tag),
    .i_set_dirty (set_dirty),                  .i_set_valid (set_valid),
    .i_replace_tag (replace_tag),              .o_hit (hit),
    .o_dirty (dirty),                          .o_tag_old (tag_old)
  );

  riscv_dcache_data u_data (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),  .i_wren (cache_wren),
    .i_insel (cache_insel),                    .i_index (index),
    .i_byte_offset (byte_offset),              .i_store_src (i_riscv_dcache_store_src),
    .i_data_in (cache_data_in),                .o_data_out (cache_data_out)
  );

  riscv_dcache_dram u_dram (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),  .i_riscv_dcache_rst (i_riscv_dcache_rst),
    .i_wren (mem_wren),                        .i_rden (mem_rden),
    .i_addr (mem_addr),                        .i_data_in (cache_data_out),
    .o_data_out (mem_data_out),                .o_mem_ready (mem_ready)
  );

  riscv_amo_unit u_amo (
    .i_amo_op (i_riscv_dcache_amo_op),         .i_rs1data (amo_old),
    .i_rs2data (i_riscv_dcache_cpu_data_in),   .i_enable (cache_insel == INSEL_AMO),
    .o_result (amo_result)
  );

endmodule

`default_nettype wire

/* verification/riscv_dcache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_dcache_checker (
  input  logic                         i_riscv_dcache_clk,
  input  logic                         i_riscv_dcache_rst,
  input  logic                         i_globstall,
  input  logic                         i_cpu_wren,
  input  logic                         i_cpu_rden,
  input  logic                         i_amo,
  input  riscv_dcache_pkg::store_src_t i_store_src,
  input  riscv_dcache_pkg::amo_op_t    i_amo_op,
  input  logic [63:0]                  i_phys_addr,
  input  logic [63:0]                  i_cpu_data_in,
  input  logic [63:0]                  i_cpu_data_out,
  input  logic                         i_cpu_stall,
  output int                           o_error_count,
  output int                           o_check_count
);
  import riscv_dcache_pkg::*;

  logic [7:0]      mem [1 << ADDR];  // byte model of the 4 KB space
  logic [ADDR-1:0] base;
  logic [63:0]     old_value;
  int              errors = 0;
  int              checks = 0;

  assign o_error_count = errors;
  assign o_check_count = checks;

  //////////////////// model helpers
  function automatic logic [63:0] read_dword(input logic [ADDR-1:0] a);
    logic [63:0]     d;
    logic [ADDR-1:0] p;
    for (int k = 0; k < 8; k++) begin
      p = a + ADDR'(k);
      d[8*k +: 8] = mem[p];
    end
    return d;
  endfunction

  task automatic write_bytes(input logic [ADDR-1:0] a, input logic [63:0] d, input int n);
    logic [ADDR-1:0] p;
    for (int k = 0; k < n; k++) begin
      p = a + ADDR'(k);
      mem[p] = d[8*k +: 8];  // low bytes land at the address
    end
  endtask

  function automatic int width_bytes(input store_src_t w);
    case (w)
      ST_BYTE: return 1;
      ST_HALF: return 2;
      ST_WORD: return 4;
      default: return 8;
    endcase
  endfunction

  // riscv A extension rules, 64-bit
  function automatic logic [63:0] amo_value(input amo_op_t op, input logic [63:0] a,
                                            input logic [63:0] b);
    case (op)
      AMOADD:  return a + b;
      AMOSWAP: return b;
      AMOXOR:  return a ^ b;
      AMOOR:   return a | b;
      AMOAND:  return a & b;
      AMOMIN:  return ($signed(a) < $signed(b)) ? a : b;
      AMOMAX:  return ($signed(a) > $signed(b)) ? a : b;
      AMOMINU: return (a < b) ? a : b;
      default: return (a > b) ? a : b;  // AMOMAXU
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s addr %h: expected %h, actual %h", name, i_phys_addr, exp, act);
    end
  endtask

  //////////////////// watch the ports
  // mid-cycle sample, a request seen free here completes on the next edge
  always @(negedge i_riscv_dcache_clk) begin
    if (i_riscv_dcache_rst) begin
      for (int i = 0; i < (1 << ADDR); i++) begin
        mem[ADDR'(i)] = 8'h00;  // dram is zeroed too
      end
    end else if (!(i_cpu_rden | i_cpu_wren | i_amo)) begin
      compare_value("o_riscv_dcache_cpu_stall", 64'd0, {63'd0, i_cpu_stall});
    end else if (!i_cpu_stall && !i_globstall) begin
      base = {i_phys_addr[ADDR-1:3], 3'b000};
      if (i_cpu_rden) begin
        compare_value("o_riscv_dcache_cpu_data_out", read_dword(base), i_cpu_data_out);
      end else if (i_cpu_wren) begin
        write_bytes(i_phys_addr[ADDR-1:0], i_cpu_data_in, width_bytes(i_store_src));
      end else begin
        old_value = read_dword(base);
        compare_value("o_riscv_dcache_cpu_data_out", old_value, i_cpu_data_out);
        write_bytes(base, amo_value(i_amo_op, old_value, i_cpu_data_in), 8);
      end
    end
  end

endmodule

`default_nettype wire

/* verification/riscv_dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_dcache_tb;
  import riscv_dcache_pkg::*;

  logic        clk, rst, globstall, wren, rden, amo, stall;
  store_src_t  store_src;
  amo_op_t     amo_op;
  logic [63:0] phys_addr, data_in, data_out;
  int          seed;
  int          timeouts = 0;
  int          error_count, check_count;

  riscv_data_cache uut (
    .i_riscv_dcache_clk (clk),              .i_riscv_dcache_rst (rst),
    .i_riscv_dcache_globstall (globstall),  .i_riscv_dcache_cpu_wren (wren),
    .i_riscv_dcache_cpu_rden (rden),        .i_riscv_dcache_amo (amo),
    .i_riscv_dcache_store_src (store_src),  .i_riscv_dcache_amo_op (amo_op),
    .i_riscv_dcache_phys_addr (phys_addr),  .i_riscv_dcache_cpu_data_in (data_in),
    .o_riscv_dcache_cpu_data_out (data_out), .o_riscv_dcache_cpu_stall (stall)
  );

  riscv_dcache_checker u_checker (
    .i_riscv_dcache_clk (clk),   .i_riscv_dcache_rst (rst),   .i_globstall (globstall),
    .i_cpu_wren (wren),          .i_cpu_rden (rden),          .i_amo (amo),
    .i_store_src (store_src),    .i_amo_op (amo_op),          .i_phys_addr (phys_addr),
    .i_cpu_data_in (data_in),    .i_cpu_data_out (data_out),  .i_cpu_stall (stall),
    .o_error_count (error_count), .o_check_count (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic store_src_t pick_width(input int unsigned n);
    case (n)
      0:       return ST_BYTE;
      1:       return ST_HALF;
      2:       return ST_WORD;
      default: return ST_DOUBLE;
    endcase
  endfunction

  function automatic amo_op_t pick_amo(input int unsigned n);
    case (n)
      0:       return AMOADD;
      1:       return AMOSWAP;
      2:       return AMOXOR;
      3:       return AMOOR;
      4:       return AMOAND;
      5:       return AMOMIN;
      6:       return AMOMAX;
      7:       return AMOMINU;
      default: return AMOMAXU;
    endcase
  endfunction

  //////////////////// one request
  task automatic issue_request(input int n);
    int unsigned kind;
    int unsigned cycles;
    logic [3:0]  tg, ix, off, nbytes;
    logic        done;
    kind      = rand_below(20);
    store_src = pick_width(rand_below(4));
    amo_op    = pick_amo(rand_below(9));
    tg        = 4'(rand_below(8));  // few tags on few lines so conflicts are common
    ix        = (rand_below(8) == 0) ? 4'(rand_below(16)) : 4'(rand_below(4));
    off       = 4'(rand_below(16));
    nbytes    = (kind >= 15) ? 4'd8 : 4'd1 << store_src;
    off       = off & ~(nbytes - 4'd1);  // natural alignment
    phys_addr = {$random(seed), $random(seed)};
    phys_addr[11:0] = {tg, ix, off};
    data_in   = {$random(seed), $random(seed)};
    rden      = (kind < 7);
    wren      = (kind >= 7) && (kind < 15);
    amo       = (kind >= 15) && (kind < 19);  // 19 leaves an idle cycle
    done      = 1'b0;
    cycles    = 0;
    while (!done && cycles < 200) begin
      @(negedge clk);
      done = !stall && !globstall;
      @(posedge clk);
      #2;
      globstall = (rand_below(8) == 0);
      cycles++;
    end
    rden = 1'b0;
    wren = 1'b0;
    amo  = 1'b0;
    if (!done) begin
      $display("timeout: request %0d at address %h still stalled after 200 cycles",
               n, phys_addr);
      timeouts++;
    end
  endtask

  //////////////////// main sequence
  initial begin
    seed      = 55319;
    rst       = 1'b1;
    globstall = 1'b0;
    wren      = 1'b0;
    rden      = 1'b0;
    amo       = 1'b0;
    store_src = ST_DOUBLE;
    amo_op    = AMOADD;
    phys_addr = 64'd0;
    data_in   = 64'd0;
    repeat (2) @(posedge clk);
    #2 rst = 1'b0;
    // one idle cycle out of reset so stall is seen low
    @(posedge clk);
    #2;
    for (int n = 0; n < 400 && timeouts == 0; n++) begin
      issue_request(n);
    end
    globstall = 1'b0;
    repeat (2) @(posedge clk);
    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
    if (error_count == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* riscv_data_cache.f */
logic/riscv_dcache_pkg.sv
logic/riscv_amo_unit.sv
logic/riscv_dcache_fsm.sv
logic/riscv_dcache_tag.sv
logic/riscv_dcache_data.sv
logic/riscv_dcache_dram.sv
logic/riscv_data_cache.sv
verification/riscv_dcache_checker.sv
verification/riscv_dcache_tb.sv

/* Makefile */
TOP := riscv_dcache_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): riscv_data_cache.f $(wildcard logic/*.sv verification/*.sv)
	verilator --binary --timing -j 0 --top-module $(TOP) -f riscv_data_cache.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
